// File: hw/csr_pkg.sv
/* Shared widths, CSR indices, addresses, bit positions and codes for the machine CSR subsystem.
   Imported by every RTL module and by the testbench. */

`default_nettype none

package csr_pkg;

    // ----------------------------------------------------------
    // Widths.
    // ----------------------------------------------------------
    localparam int XLEN       = 64; // Width of every CSR.
    localparam int CSR_IDX_W  = 3;  // Internal index width.
    localparam int CSR_ADDR_W = 12; // Architectural address width.

    // ----------------------------------------------------------
    // Internal indices.
    // ----------------------------------------------------------
    localparam logic [CSR_IDX_W-1:0] IDX_MSTATUS = 3'd0;
    localparam logic [CSR_IDX_W-1:0] IDX_MIE     = 3'd2;
    localparam logic [CSR_IDX_W-1:0] IDX_MTVEC   = 3'd3;
    localparam logic [CSR_IDX_W-1:0] IDX_MCAUSE  = 3'd4;
    localparam logic [CSR_IDX_W-1:0] IDX_MEPC    = 3'd5;
    localparam logic [CSR_IDX_W-1:0] IDX_MIP     = 3'd6;

    // Read-only identification bank, selected by the low two bits.
    localparam logic [CSR_IDX_W-1:0] IDX_MHARTID   = 3'd0;
    localparam logic [CSR_IDX_W-1:0] IDX_MVENDORID = 3'd1;
    localparam logic [CSR_IDX_W-1:0] IDX_MARCHID   = 3'd2;
    localparam logic [CSR_IDX_W-1:0] IDX_MIMPID    = 3'd3;

    localparam logic [XLEN-1:0] RO_MHARTID   = 64'h0000_0000_0000_0001;
    localparam logic [XLEN-1:0] RO_MVENDORID = 64'h0000_0000_0000_05a5;
    localparam logic [XLEN-1:0] RO_MARCHID   = 64'h0000_0000_0000_002a;
    localparam logic [XLEN-1:0] RO_MIMPID    = 64'h0000_0000_0001_0003;

    // ----------------------------------------------------------
    // Architectural CSR addresses.
    // ----------------------------------------------------------
    localparam logic [CSR_ADDR_W-1:0] ADDR_MSTATUS   = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MIE       = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MTVEC     = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MEPC      = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MCAUSE    = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MIP       = 12'h344;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MVENDORID = 12'hf11;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MARCHID   = 12'hf12;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MIMPID    = 12'hf13;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MHARTID   = 12'hf14;

    // ----------------------------------------------------------
    // Bit positions, cause codes and operations.
    // ----------------------------------------------------------
    localparam int BIT_MIE  = 3; // mstatus.
    localparam int BIT_MPIE = 7; // mstatus.
    localparam int BIT_MSI  = 3; // mip and mie.
    localparam int BIT_MTI  = 7; // mip and mie.

    localparam logic [XLEN-2:0] CAUSE_MSI = 63'd3;
    localparam logic [XLEN-2:0] CAUSE_MTI = 63'd7;

    localparam logic [1:0] CSR_OP_RW = 2'b01;
    localparam logic [1:0] CSR_OP_RS = 2'b10;
    localparam logic [1:0] CSR_OP_RC = 2'b11;

endpackage

`default_nettype wire

// File: hw/machine_timer.sv
/* Free-running mtime counter compared against a loadable mtimecmp.
   Produces the registered machine timer interrupt level. */

`timescale 1ns/1ps
`default_nettype none

module machine_timer import csr_pkg::*; (
    input  logic            clk,
    input  logic            arst,
    input  logic            i_mtimecmp_we,
    input  logic [XLEN-1:0] i_mtimecmp_data,
    output logic            o_timer_int
);

    logic [XLEN-1:0] mtime;
    logic [XLEN-1:0] mtimecmp;

    // ----------------------------------------------------------
    // Counter and compare register.
    // ----------------------------------------------------------
    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            mtime    <= '0;
            mtimecmp <= '1; // Never fires until loaded.
        end else begin
            mtime <= mtime + 1'b1;
            if (i_mtimecmp_we) begin
                mtimecmp <= i_mtimecmp_data;
            end
        end
    end

    // Level is registered, one cycle behind the compare.
    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            o_timer_int <= 1'b0;
        end else begin
            o_timer_int <= (mtime >= mtimecmp);
        end
    end

endmodule

`default_nettype wire

// File: hw/csr_file.sv
/* Machine CSR storage with two write ports, interrupt bit tracking and a banked read mux.
   Port 1 serves CSR instructions, port 2 the trap controller, which wins on conflicts. */

`timescale 1ns/1ps
`default_nettype none

module csr_file import csr_pkg::*; (
    input  logic                 clk,
    input  logic                 arst,

    // Read port.
    input  logic [CSR_IDX_W-1:0] i_read_idx,
    input  logic                 i_read_ro,
    output logic [XLEN-1:0]      o_read_data,

    // Write ports.
    input  logic                 i_we_1,
    input  logic [CSR_IDX_W-1:0] i_waddr_1,
    input  logic [XLEN-1:0]      i_wdata_1,
    input  logic                 i_we_2,
    input  logic [CSR_IDX_W-1:0] i_waddr_2,
    input  logic [XLEN-1:0]      i_wdata_2,

    // Interrupt levels and trap events.
    input  logic                 i_timer_int,
    input  logic                 i_software_int,
    input  logic                 i_interrupt_jump,
    input  logic                 i_mret,

    // Status towards the trap controller.
    output logic                 o_mstatus_mie,
    output logic                 o_mip_mtip,
    output logic                 o_mip_msip,
    output logic                 o_mie_mtie,
    output logic                 o_mie_msie,
    output logic [XLEN-1:0]      o_mtvec,
    output logic [XLEN-1:0]      o_mepc
);

    logic [XLEN-1:0] mem [2**CSR_IDX_W];
    logic [XLEN-1:0] ro_data;

    // Adjusts write data so that hardware owned bits keep their rules.
    function automatic logic [XLEN-1:0] fix_wdata(
        input logic [CSR_IDX_W-1:0] idx,
        input logic [XLEN-1:0]      data
    );
        logic [XLEN-1:0] res;

        res = data;
        if (idx == IDX_MIP) begin
            res[BIT_MTI] = i_timer_int;    // Levels always win.
            res[BIT_MSI] = i_software_int;
        end
        if (idx == IDX_MSTATUS && i_interrupt_jump) begin
            res[BIT_MIE] = 1'b0;           // No re-enable on trap entry.
        end
        return res;
    endfunction

    // ----------------------------------------------------------
    // Writable bank.
    // ----------------------------------------------------------
    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            for (int i = 0; i < 2**CSR_IDX_W; i++) begin
                mem[i] <= '0;
            end
        end else begin
            mem[IDX_MIP][BIT_MTI] <= i_timer_int;    // Track timer level.
            mem[IDX_MIP][BIT_MSI] <= i_software_int; // Track software level.

            if (i_interrupt_jump) begin
                mem[IDX_MSTATUS][BIT_MIE]  <= 1'b0;
                mem[IDX_MSTATUS][BIT_MPIE] <= mem[IDX_MSTATUS][BIT_MIE];
            end

            if (i_mret) begin
                mem[IDX_MSTATUS][BIT_MIE] <= mem[IDX_MSTATUS][BIT_MPIE];
            end

            // Port 2 comes last so it overrides port 1.
            if (i_we_1) begin
                mem[i_waddr_1] <= fix_wdata(i_waddr_1, i_wdata_1);
            end
            if (i_we_2) begin
                mem[i_waddr_2] <= fix_wdata(i_waddr_2, i_wdata_2);
            end
        end
    end

    // ----------------------------------------------------------
    // Read mux.
    // ----------------------------------------------------------
    always_comb begin
        case (i_read_idx[1:0])
            IDX_MHARTID[1:0]:   ro_data = RO_MHARTID;
            IDX_MVENDORID[1:0]: ro_data = RO_MVENDORID;
            IDX_MARCHID[1:0]:   ro_data = RO_MARCHID;
            default:            ro_data = RO_MIMPID;
        endcase
    end

    assign o_read_data = i_read_ro ? ro_data : mem[i_read_idx];

    assign o_mstatus_mie = mem[IDX_MSTATUS][BIT_MIE];
    assign o_mip_mtip    = mem[IDX_MIP][BIT_MTI];
    assign o_mip_msip    = mem[IDX_MIP][BIT_MSI];
    assign o_mie_mtie    = mem[IDX_MIE][BIT_MTI];
    assign o_mie_msie    = mem[IDX_MIE][BIT_MSI];
    assign o_mtvec       = mem[IDX_MTVEC];
    assign o_mepc        = mem[IDX_MEPC];

endmodule

`default_nettype wire

// File: hw/csr_access_unit.sv
/* Executes CSRRW, CSRRS and CSRRC strobes from the core against the CSR file.
   The old value and the illegal flag come back combinationally in the same cycle. */

`timescale 1ns/1ps
`default_nettype none

module csr_access_unit import csr_pkg::*; (
    // Core request.
    input  logic                  i_csr_valid,
    input  logic [1:0]            i_csr_op,
    input  logic [CSR_ADDR_W-1:0] i_csr_addr,
    input  logic [XLEN-1:0]       i_csr_wdata,
    output logic [XLEN-1:0]       o_csr_rdata,
    output logic                  o_csr_illegal,

    // CSR file read port.
    output logic [CSR_IDX_W-1:0]  o_read_idx,
    output logic                  o_read_ro,
    input  logic [XLEN-1:0]       i_read_data,

    // CSR file write port 1.
    output logic                  o_we,
    output logic [CSR_IDX_W-1:0]  o_waddr,
    output logic [XLEN-1:0]       o_wdata
);

    logic            known;
    logic            write_req;
    logic [XLEN-1:0] old_value;

    // ----------------------------------------------------------
    // Address decode.
    // ----------------------------------------------------------
    always_comb begin
        known      = 1'b1;
        o_read_ro  = 1'b0;
        o_read_idx = IDX_MSTATUS;
        case (i_csr_addr)
            ADDR_MSTATUS:   o_read_idx = IDX_MSTATUS;
            ADDR_MIE:       o_read_idx = IDX_MIE;
            ADDR_MTVEC:     o_read_idx = IDX_MTVEC;
            ADDR_MEPC:      o_read_idx = IDX_MEPC;
            ADDR_MCAUSE:    o_read_idx = IDX_MCAUSE;
            ADDR_MIP:       o_read_idx = IDX_MIP;
            ADDR_MHARTID:   begin o_read_ro = 1'b1; o_read_idx = IDX_MHARTID;   end
            ADDR_MVENDORID: begin o_read_ro = 1'b1; o_read_idx = IDX_MVENDORID; end
            ADDR_MARCHID:   begin o_read_ro = 1'b1; o_read_idx = IDX_MARCHID;   end
            ADDR_MIMPID:    begin o_read_ro = 1'b1; o_read_idx = IDX_MIMPID;    end
            default:        known = 1'b0;
        endcase
    end

    assign old_value = known ? i_read_data : '0; // Unknown reads zero.

    // ----------------------------------------------------------
    // Read-modify-write.
    // ----------------------------------------------------------
    always_comb begin
        write_req = 1'b0;
        o_wdata   = old_value;
        case (i_csr_op)
            CSR_OP_RW: begin
                write_req = 1'b1;
                o_wdata   = i_csr_wdata;
            end
            CSR_OP_RS: begin
                write_req = |i_csr_wdata; // Zero source only reads.
                o_wdata   = old_value | i_csr_wdata;
            end
            CSR_OP_RC: begin
                write_req = |i_csr_wdata;
                o_wdata   = old_value & ~i_csr_wdata;
            end
            default: write_req = 1'b0;
        endcase
    end

    assign o_csr_rdata   = old_value;
    assign o_csr_illegal = i_csr_valid & (~known | (o_read_ro & write_req));
    assign o_we          = i_csr_valid & known & ~o_read_ro & write_req;
    assign o_waddr       = o_read_idx;

endmodule

`default_nettype wire

// File: hw/trap_controller.sv
/* Interrupt arbitration and trap entry sequencing, plus the MRET return redirect.
   Trap entry writes mcause, then mepc, through the second CSR file write port. */

`timescale 1ns/1ps
`default_nettype none

module trap_controller import csr_pkg::*; (
    input  logic                 clk,
    input  logic                 arst,

    // Status from the CSR file.
    input  logic                 i_mstatus_mie,
    input  logic                 i_mip_mtip,
    input  logic                 i_mip_msip,
    input  logic                 i_mie_mtie,
    input  logic                 i_mie_msie,
    input  logic [XLEN-1:0]      i_mtvec,
    input  logic [XLEN-1:0]      i_mepc,

    // Core side.
    input  logic [XLEN-1:0]      i_pc,
    input  logic                 i_mret,

    // CSR file write port 2 and events.
    output logic                 o_we,
    output logic [CSR_IDX_W-1:0] o_waddr,
    output logic [XLEN-1:0]      o_wdata,
    output logic                 o_interrupt_jump,
    output logic                 o_mret,

    // Redirect to the core.
    output logic                 o_trap_busy,
    output logic                 o_redirect_valid,
    output logic [XLEN-1:0]      o_redirect_pc
);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_CAUSE = 2'd1;
    localparam logic [1:0] ST_EPC   = 2'd2;

    logic [1:0] state;
    logic       cause_msi;
    logic       mret_q;
    logic       msi_pend;
    logic       mti_pend;

    assign msi_pend = i_mip_msip & i_mie_msie;
    assign mti_pend = i_mip_mtip & i_mie_mtie;

    // ----------------------------------------------------------
    // Trap entry FSM.
    // ----------------------------------------------------------
    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            state     <= ST_IDLE;
            cause_msi <= 1'b0;
            mret_q    <= 1'b0;
        end else begin
            mret_q <= i_mret; // Redirect one cycle after MRET.
            case (state)
                ST_IDLE: begin
                    if (i_mstatus_mie & (msi_pend | mti_pend)) begin
                        state     <= ST_CAUSE;
                        cause_msi <= msi_pend; // Software beats timer.
                    end
                end
                ST_CAUSE: state <= ST_EPC;
                default:  state <= ST_IDLE;
            endcase
        end
    end

    assign o_trap_busy      = (state != ST_IDLE);
    assign o_interrupt_jump = (state == ST_CAUSE);
    assign o_we             = (state == ST_CAUSE) | (state == ST_EPC);
    assign o_waddr          = (state == ST_CAUSE) ? IDX_MCAUSE : IDX_MEPC;
    assign o_wdata          = (state == ST_CAUSE) ?
                              {1'b1, (cause_msi ? CAUSE_MSI : CAUSE_MTI)} : i_pc;
    assign o_mret           = i_mret;

    // Direct mode only, so the base drops its mode bits.
    assign o_redirect_valid = (state == ST_EPC) | mret_q;
    assign o_redirect_pc    = (state == ST_EPC) ? {i_mtvec[XLEN-1:2], 2'b00} : i_mepc;

endmodule

`default_nettype wire

// File: hw/csr_subsystem.sv
/* Top level of the machine CSR subsystem, tying the CSR file, access unit,
   trap controller and machine timer to the core-side strobes. */

`timescale 1ns/1ps
`default_nettype none

module csr_subsystem import csr_pkg::*; (
    input  logic                  clk,
    input  logic                  arst,

    // CSR instruction interface.
    input  logic                  i_csr_valid,
    input  logic [1:0]            i_csr_op,
    input  logic [CSR_ADDR_W-1:0] i_csr_addr,
    input  logic [XLEN-1:0]       i_csr_wdata,
    output logic [XLEN-1:0]       o_csr_rdata,
    output logic                  o_csr_illegal,

    // Control flow and interrupts.
    input  logic [XLEN-1:0]       i_pc,
    input  logic                  i_mret,
    input  logic                  i_msip,
    input  logic                  i_mtimecmp_we,
    input  logic [XLEN-1:0]       i_mtimecmp_data,
    output logic                  o_redirect_valid,
    output logic [XLEN-1:0]       o_redirect_pc,
    output logic                  o_trap_busy
);

    logic [CSR_IDX_W-1:0] read_idx;
    logic                 read_ro;
    logic [XLEN-1:0]      read_data;
    logic                 we_1;
    logic                 we_2;
    logic [CSR_IDX_W-1:0] waddr_1;
    logic [CSR_IDX_W-1:0] waddr_2;
    logic [XLEN-1:0]      wdata_1;
    logic [XLEN-1:0]      wdata_2;
    logic                 timer_int;
    logic                 interrupt_jump;
    logic                 mret;
    logic                 mstatus_mie;
    logic                 mip_mtip;
    logic                 mip_msip;
    logic                 mie_mtie;
    logic                 mie_msie;
    logic [XLEN-1:0]      mtvec;
    logic [XLEN-1:0]      mepc;

    csr_access_unit u_access (
        .i_csr_valid   (i_csr_valid),
        .i_csr_op      (i_csr_op),
        .i_csr_addr    (i_csr_addr),
        .i_csr_wdata   (i_csr_wdata),
        .o_csr_rdata   (o_csr_rdata),
        .o_csr_illegal (o_csr_illegal),
        .o_read_idx    (read_idx),
        .o_read_ro     (read_ro),
        .i_read_data   (read_data),
        .o_we          (we_1),
        .o_waddr       (waddr_1),
        .o_wdata       (wdata_1)
    );

    csr_file u_file (
        .clk              (clk),
        .arst             (arst),
        .i_read_idx       (read_idx),
        .i_read_ro        (read_ro),
        .o_read_data      (read_data),
        .i_we_1           (we_1),
        .i_waddr_1        (waddr_1),
        .i_wdata_1        (wdata_1),
        .i_we_2           (we_2),
        .i_waddr_2        (waddr_2),
        .i_wdata_2        (wdata_2),
        .i_timer_int      (timer_int),
        .i_software_int   (i_msip),
        .i_interrupt_jump (interrupt_jump),
        .i_mret           (mret),
        .o_mstatus_mie    (mstatus_mie),
        .o_mip_mtip       (mip_mtip),
        .o_mip_msip       (mip_msip),
        .o_mie_mtie       (mie_mtie),
        .o_mie_msie       (mie_msie),
        .o_mtvec          (mtvec),
        .o_mepc           (mepc)
    );

    trap_controller u_trap (
        .clk              (clk),
        .arst             (arst),
        .i_mstatus_mie    (mstatus_mie),
        .i_mip_mtip       (mip_mtip),
        .i_mip_msip       (mip_msip),
        .i_mie_mtie       (mie_mtie),
        .i_mie_msie       (mie_msie),
        .i_mtvec          (mtvec),
        .i_mepc           (mepc),
        .i_pc             (i_pc),
        .i_mret           (i_mret),
        .o_we             (we_2),
        .o_waddr          (waddr_2),
        .o_wdata          (wdata_2),
        .o_interrupt_jump (interrupt_jump),
        .o_mret           (mret),
        .o_trap_busy      (o_trap_busy),
        .o_redirect_valid (o_redirect_valid),
        .o_redirect_pc    (o_redirect_pc)
    );

    machine_timer u_timer (
        .clk             (clk),
        .arst            (arst),
        .i_mtimecmp_we   (i_mtimecmp_we),
        .i_mtimecmp_data (i_mtimecmp_data),
        .o_timer_int     (timer_int)
    );

endmodule

`default_nettype wire

// File: sim/csr_subsystem_tb.sv
/* Self-checking testbench for the machine CSR subsystem, with a CSR model,
   random and directed CSR accesses, timer and software trap entry and MRET. */

`timescale 1ns/1ps
`default_nettype none

module csr_subsystem_tb import csr_pkg::*; ();

    localparam int              CLK_PERIOD = 40;
    localparam int              NUM_RANDOM = 200;
    localparam int              NUM_OPS    = 2 * NUM_RANDOM + 100; // Sizes the watchdog.
    localparam int              TRAP_WAIT  = 100;
    localparam logic [XLEN-1:0] TRAP_VEC   = 64'h0000_0000_8000_1003; // Mode bits set.
    localparam logic [XLEN-1:0] PC_TIMER   = 64'h0000_0000_8000_0a40;
    localparam logic [XLEN-1:0] PC_SOFT    = 64'h0000_0000_8000_2c18;

    logic                  clk;
    logic                  arst;
    logic                  i_csr_valid;
    logic [1:0]            i_csr_op;
    logic [CSR_ADDR_W-1:0] i_csr_addr;
    logic [XLEN-1:0]       i_csr_wdata;
    logic [XLEN-1:0]       o_csr_rdata;
    logic                  o_csr_illegal;
    logic [XLEN-1:0]       i_pc;
    logic                  i_mret;
    logic                  i_msip;
    logic                  i_mtimecmp_we;
    logic [XLEN-1:0]       i_mtimecmp_data;
    logic                  o_redirect_valid;
    logic [XLEN-1:0]       o_redirect_pc;
    logic                  o_trap_busy;

    // Model state and expected response of the access in flight.
    logic [XLEN-1:0]       model_csr [8];
    logic                  lvl_mtip;
    logic                  lvl_msip;
    logic                  exp_valid;
    logic [XLEN-1:0]       exp_rdata;
    logic                  exp_illegal;
    logic [CSR_ADDR_W-1:0] exp_addr;
    int                    checks_done;
    logic [XLEN-1:0]       cycles;

    csr_subsystem dut (
        .clk              (clk),
        .arst             (arst),
        .i_csr_valid      (i_csr_valid),
        .i_csr_op         (i_csr_op),
        .i_csr_addr       (i_csr_addr),
        .i_csr_wdata      (i_csr_wdata),
        .o_csr_rdata      (o_csr_rdata),
        .o_csr_illegal    (o_csr_illegal),
        .i_pc             (i_pc),
        .i_mret           (i_mret),
        .i_msip           (i_msip),
        .i_mtimecmp_we    (i_mtimecmp_we),
        .i_mtimecmp_data  (i_mtimecmp_data),
        .o_redirect_valid (o_redirect_valid),
        .o_redirect_pc    (o_redirect_pc),
        .o_trap_busy      (o_trap_busy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Mirrors mtime, which counts from zero after reset.
    always @(posedge clk or posedge arst) begin
        if (arst) begin
            cycles <= '0;
        end else begin
            cycles <= cycles + 1'b1;
        end
    end

    // ----------------------------------------------------------
    // Checking helpers.
    // ----------------------------------------------------------
    task automatic check_eq(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                            input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s: got %h, expected %h", $time, what, got, exp);
            $display(">>> FAIL");
            $fatal(1, "Stopped at the first mismatch.");
        end
    endtask

    task automatic abort_run(input string why);
        $display("ERROR at %0t: %s", $time, why);
        $display(">>> FAIL");
        $fatal(1, "Run aborted.");
    endtask

    // Outputs are sampled at the rising edge, half a cycle after the drive.
    always @(posedge clk) begin
        if (exp_valid) begin
            check_eq(o_csr_rdata, exp_rdata, $sformatf("old value of CSR %03h", exp_addr));
            check_eq(o_csr_illegal, exp_illegal, $sformatf("illegal flag of CSR %03h", exp_addr));
            checks_done++;
        end
    end

    // ----------------------------------------------------------
    // Reference model.
    // ----------------------------------------------------------
    function automatic void model_access(
        input  logic [1:0]            op,
        input  logic [CSR_ADDR_W-1:0] addr,
        input  logic [XLEN-1:0]       src,
        output logic [XLEN-1:0]       old_v,
        output logic                  illegal,
        output logic [XLEN-1:0]       new_v,
        output logic                  wr,
        output int                    idx
    );
        logic            known;
        logic            ro;
        logic [XLEN-1:0] ro_v;

        known = 1'b1;
        idx   = -1;
        ro_v  = '0;
        case (addr)
            ADDR_MSTATUS:   idx = IDX_MSTATUS;
            ADDR_MIE:       idx = IDX_MIE;
            ADDR_MTVEC:     idx = IDX_MTVEC;
            ADDR_MEPC:      idx = IDX_MEPC;
            ADDR_MCAUSE:    idx = IDX_MCAUSE;
            ADDR_MIP:       idx = IDX_MIP;
            ADDR_MHARTID:   ro_v = RO_MHARTID;
            ADDR_MVENDORID: ro_v = RO_MVENDORID;
            ADDR_MARCHID:   ro_v = RO_MARCHID;
            ADDR_MIMPID:    ro_v = RO_MIMPID;
            default:        known = 1'b0;
        endcase
        ro = known && (idx < 0);

        if (!known) begin
            old_v = '0;
        end else if (ro) begin
            old_v = ro_v;
        end else begin
            old_v = model_csr[idx];
            if (idx == IDX_MIP) begin
                old_v[BIT_MTI] = lvl_mtip; // Pending bits show the levels.
                old_v[BIT_MSI] = lvl_msip;
            end
        end

        new_v = old_v;
        wr    = 1'b0;
        if (op == CSR_OP_RW) begin
            new_v = src;
            wr    = 1'b1;
        end else if (op == CSR_OP_RS) begin
            new_v = old_v | src;
            wr    = (src != '0);
        end else if (op == CSR_OP_RC) begin
            new_v = old_v & ~src;
            wr    = (src != '0);
        end
        illegal = !known || (ro && wr);
        wr      = wr && known && !ro;
    endfunction

    function automatic void model_trap(input logic [XLEN-2:0] code, input logic [XLEN-1:0] pc);
        model_csr[IDX_MCAUSE]                = {1'b1, code};
        model_csr[IDX_MEPC]                  = pc;
        model_csr[IDX_MSTATUS][BIT_MPIE]     = model_csr[IDX_MSTATUS][BIT_MIE];
        model_csr[IDX_MSTATUS][BIT_MIE]      = 1'b0;
    endfunction

    function automatic void model_mret();
        model_csr[IDX_MSTATUS][BIT_MIE] = model_csr[IDX_MSTATUS][BIT_MPIE];
    endfunction

    // ----------------------------------------------------------
    // Stimulus.
    // ----------------------------------------------------------
    task automatic bus_idle();
        i_csr_valid   = 1'b0;
        exp_valid     = 1'b0;
        i_mret        = 1'b0;
        i_mtimecmp_we = 1'b0;
    endtask

    // Leaves the strobe up so that a following access runs back to back.
    task automatic csr_access(input logic [1:0] op, input logic [CSR_ADDR_W-1:0] addr,
                              input logic [XLEN-1:0] src);
        logic [XLEN-1:0] old_v;
        logic [XLEN-1:0] new_v;
        logic            illegal;
        logic            wr;
        int              idx;

        @(negedge clk);
        model_access(op, addr, src, old_v, illegal, new_v, wr, idx);
        i_csr_valid = 1'b1;
        i_csr_op    = op;
        i_csr_addr  = addr;
        i_csr_wdata = src;
        exp_rdata   = old_v;
        exp_illegal = illegal;
        exp_addr    = addr;
        exp_valid   = 1'b1;
        @(posedge clk);
        if (wr) begin
            model_csr[idx] = new_v;
        end
    endtask

    task automatic csr_read(input logic [CSR_ADDR_W-1:0] addr);
        csr_access(CSR_OP_RS, addr, '0); // Zero source reads only.
    endtask

    task automatic read_all();
        csr_read(ADDR_MSTATUS);
        csr_read(ADDR_MIE);
        csr_read(ADDR_MTVEC);
        csr_read(ADDR_MEPC);
        csr_read(ADDR_MCAUSE);
        csr_read(ADDR_MIP);
        csr_read(ADDR_MHARTID);
        csr_read(ADDR_MVENDORID);
        csr_read(ADDR_MARCHID);
        csr_read(ADDR_MIMPID);
    endtask

    function automatic logic [1:0] random_op();
        case ($urandom_range(0, 2))
            0:       return CSR_OP_RW;
            1:       return CSR_OP_RS;
            default: return CSR_OP_RC;
        endcase
    endfunction

    function automatic logic [CSR_ADDR_W-1:0] random_target();
        case ($urandom_range(0, 4))
            0:       return ADDR_MTVEC;
            1:       return ADDR_MEPC;
            2:       return ADDR_MCAUSE;
            3:       return ADDR_MIE;
            default: return ADDR_MSTATUS;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] random_src();
        if ($urandom_range(0, 7) == 0) begin
            return '0;
        end
        return {$urandom, $urandom};
    endfunction

    task automatic load_mtimecmp(input logic [XLEN-1:0] value);
        @(negedge clk);
        bus_idle();
        i_mtimecmp_we   = 1'b1;
        i_mtimecmp_data = value;
        @(negedge clk);
        i_mtimecmp_we   = 1'b0;
    endtask

    // Busy for one cycle, then the redirect to the trap vector.
    task automatic wait_for_trap(input logic [XLEN-1:0] target);
        int waited;

        @(negedge clk);
        bus_idle();
        waited = 0;
        @(posedge clk);
        while (o_trap_busy !== 1'b1) begin
            waited++;
            if (waited > TRAP_WAIT) begin
                abort_run("trap entry did not start in time");
            end
            @(posedge clk);
        end
        check_eq(o_redirect_valid, 1'b0, "redirect in the first busy cycle");
        @(posedge clk);
        check_eq(o_redirect_valid, 1'b1, "trap redirect one cycle after busy");
        check_eq(o_redirect_pc, target, "trap redirect target");
    endtask

    task automatic expect_no_trap(input int n);
        @(negedge clk);
        bus_idle();
        repeat (n) begin
            @(posedge clk);
            check_eq(o_trap_busy, 1'b0, "trap taken with MIE clear");
        end
    endtask

    task automatic do_mret();
        @(negedge clk);
        bus_idle();
        i_mret = 1'b1;
        @(posedge clk);
        check_eq(o_redirect_valid, 1'b0, "redirect in the MRET cycle");
        @(negedge clk);
        i_mret = 1'b0;
        @(posedge clk);
        check_eq(o_redirect_valid, 1'b1, "MRET redirect valid");
        check_eq(o_redirect_pc, model_csr[IDX_MEPC], "MRET redirect target");
        model_mret();
    endtask

    // ----------------------------------------------------------
    // Watchdog and main sequence.
    // ----------------------------------------------------------
    initial begin
        repeat (NUM_OPS * 50) @(posedge clk);
        abort_run($sformatf("watchdog expired after %0d cycles", NUM_OPS * 50));
    end

    initial begin
        int unsigned     rng_init;
        logic [31:0]     rnd;
        logic [1:0]      op;
        logic [CSR_ADDR_W-1:0] addr;

        $timeformat(-9, 0, " ns", 0);
        rng_init        = $urandom(32'ha833);
        arst            = 1'b1;
        i_csr_op        = CSR_OP_RS;
        i_csr_addr      = '0;
        i_csr_wdata     = '0;
        i_pc            = '0;
        i_msip          = 1'b0;
        i_mtimecmp_data = '0;
        bus_idle();
        lvl_mtip        = 1'b0;
        lvl_msip        = 1'b0;
        checks_done     = 0;
        for (int i = 0; i < 8; i++) begin
            model_csr[i] = '0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst = 1'b0;

        read_all(); // Reset values and identification constants.

        for (int i = 0; i < NUM_RANDOM; i++) begin
            op   = random_op();
            addr = random_target();
            csr_access(op, addr, random_src());
            csr_read(addr); // New value visible one cycle later.
        end

        // Unknown addresses in the custom range, then writes to the ID bank.
        for (int i = 0; i < 16; i++) begin
            rnd = $urandom;
            csr_access(random_op(), {6'b011111, rnd[5:0]}, random_src());
        end
        csr_access(CSR_OP_RW, ADDR_MHARTID, {$urandom, $urandom} | 64'h1);
        csr_access(CSR_OP_RS, ADDR_MVENDORID, 64'hff);
        csr_access(CSR_OP_RC, ADDR_MARCHID, '1);
        csr_access(CSR_OP_RW, ADDR_MIMPID, 64'h1);
        read_all();

        // Timer interrupt.
        @(negedge clk);
        bus_idle();
        i_pc = PC_TIMER;
        csr_access(CSR_OP_RW, ADDR_MTVEC, TRAP_VEC);
        csr_access(CSR_OP_RW, ADDR_MIE, 64'h1 << BIT_MTI);
        csr_access(CSR_OP_RW, ADDR_MSTATUS, 64'h1 << BIT_MIE);
        load_mtimecmp(cycles + 20);
        wait_for_trap(model_csr[IDX_MTVEC] & ~64'h3);
        model_trap(CAUSE_MTI, PC_TIMER);
        lvl_mtip = 1'b1;
        read_all();
        expect_no_trap(10);

        // Software and timer both pending, software must win.
        @(negedge clk);
        bus_idle();
        i_msip = 1'b1;
        i_pc   = PC_SOFT;
        csr_access(CSR_OP_RW, ADDR_MIE, (64'h1 << BIT_MSI) | (64'h1 << BIT_MTI));
        csr_access(CSR_OP_RS, ADDR_MSTATUS, 64'h1 << BIT_MIE);
        wait_for_trap(model_csr[IDX_MTVEC] & ~64'h3);
        model_trap(CAUSE_MSI, PC_SOFT);
        lvl_msip = 1'b1;
        read_all();
        expect_no_trap(10);

        // Return with nothing enabled left pending.
        @(negedge clk);
        bus_idle();
        i_msip   = 1'b0;
        lvl_msip = 1'b0;
        csr_access(CSR_OP_RW, ADDR_MIE, '0);
        do_mret();
        csr_read(ADDR_MSTATUS);
        csr_read(ADDR_MEPC);
        expect_no_trap(10);

        if (checks_done > 2 * NUM_RANDOM) begin
            $display(">>> PASS");
            $finish;
        end else begin
            abort_run($sformatf("only %0d accesses were checked", checks_done));
        end
    end

endmodule

`default_nettype wire

// File: list.f
hw/csr_pkg.sv
hw/machine_timer.sv
hw/csr_file.sv
hw/csr_access_unit.sv
hw/trap_controller.sv
hw/csr_subsystem.sv
sim/csr_subsystem_tb.sv

// File: Bender.yml
package:
  name: csr_subsystem

sources:
  - files:
      - hw/csr_pkg.sv
      - hw/machine_timer.sv
      - hw/csr_file.sv
      - hw/csr_access_unit.sv
      - hw/trap_controller.sv
      - hw/csr_subsystem.sv
  - target: simulation
    files:
      - sim/csr_subsystem_tb.sv
